//--- hw/rsc_defines.svh
/*
  Sizing constants for the duobinary RSC encoder core.
  Included by both packages and by any module that sizes storage directly.
  Change the address width here to support longer frames.
*/

`ifndef RSC_DEFINES_SVH
`define RSC_DEFINES_SVH

//------------------------------
// Frame buffer geometry
//------------------------------

// Pair address width. A frame holds up to 2**RSC_ADDR_W pairs.
`define RSC_ADDR_W 8

// Ping-pong banks. The bank pointers wrap, so keep this a power of two.
`define RSC_NBANK 2

//------------------------------
// Constituent code
//------------------------------

// State register width of the 8-state duobinary code (s1,s2,s3).
`define RSC_STATE_W 3

`endif

//--- hw/rsc_buf_pkg.sv
/*
  Types that describe the ping-pong frame buffer.
  Shared by the source, the buffer, the engine and the top level.
  The testbench imports it to size its frame model.
*/

`include "rsc_defines.svh"

package rsc_buf_pkg;

  //------------------------------
  // Addressing
  //------------------------------

  // Pair address inside one bank.
  typedef logic [`RSC_ADDR_W-1:0] buf_addr_t;

  // Stored frame length, kept as length minus one.
  typedef logic [`RSC_ADDR_W-1:0] buf_len_t;

  //------------------------------
  // Banks
  //------------------------------

  // Bank index. One bit for the two-bank ping-pong.
  typedef logic [$clog2(`RSC_NBANK)-1:0] bank_t;

endpackage

//--- hw/rsc_code_pkg.sv
/*
  Types and the per-pair rule of the 8-state duobinary recursive code.
  The engine calls the functions once per pair, and a behavioural model
  can call the same functions to predict the parity.
*/

`include "rsc_defines.svh"

package rsc_code_pkg;

  //------------------------------
  // Data types
  //------------------------------

  typedef logic [1:0]              sym_t;        // Pair {A,B}.
  typedef logic [`RSC_STATE_W-1:0] enc_state_t;  // State {s1,s2,s3}.
  typedef logic [1:0]              par_t;        // Parity {Y,W}.

  localparam int SYM_A = 1;  // Bit of A in sym_t.
  localparam int SYM_B = 0;  // Bit of B in sym_t.
  localparam int ST_S1 = 2;  // Bit positions in enc_state_t.
  localparam int ST_S2 = 1;
  localparam int ST_S3 = 0;

  //------------------------------
  // Code rule
  //------------------------------

  function automatic logic code_fb(sym_t sym, enc_state_t st);
    return sym[SYM_A] ^ sym[SYM_B] ^ st[ST_S1] ^ st[ST_S3];  // Recursive feedback.
  endfunction

  function automatic enc_state_t code_next(sym_t sym, enc_state_t st);
    logic f;
    f = code_fb(sym, st);
    return {f, st[ST_S1] ^ sym[SYM_B], st[ST_S2] ^ sym[SYM_B]};  // Shift with B injected.
  endfunction

  function automatic par_t code_par(sym_t sym, enc_state_t st);
    logic f;
    f = code_fb(sym, st);
    return {f ^ st[ST_S2] ^ st[ST_S3], f ^ st[ST_S3]};  // {Y,W} from the current state.
  endfunction

endpackage

//--- hw/rsc_enc_source.sv
/*
  Input side of the encoder. Turns the framed pair stream into buffer
  writes and a bank-close strobe on the last pair, and presents the
  buffer flags as ready and busy. The producer starts a frame only
  while ordy is high and then finishes it; ival may gap inside a frame.
*/

module rsc_enc_source (
  input  logic                   iclk,
  input  logic                   reset,
  input  logic                   iclkena,
  input  logic                   ival,
  input  logic                   isop,
  input  logic                   ieop,
  input  rsc_code_pkg::sym_t     idat,
  input  logic                   empty_all,
  input  logic                   full_all,
  output logic                   obusy,
  output logic                   ordy,
  output logic                   write,
  output logic                   wfull,
  output rsc_buf_pkg::buf_addr_t waddr,
  output rsc_code_pkg::sym_t     wdat
);

  import rsc_buf_pkg::*;

  buf_addr_t addr_cnt;  // Address of the next pair.
  logic      in_frame;  // Between sop and eop.

  //------------------------------
  // Write path
  //------------------------------

  assign write = ival;                      // Every valid pair is stored.
  assign wfull = ival & ieop;               // Last pair closes the bank.
  assign waddr = isop ? '0 : addr_cnt;      // Sop restarts at zero.
  assign wdat  = idat;

  always_ff @(posedge iclk) begin
    if (reset) begin
      addr_cnt <= '0;
      in_frame <= 1'b0;
    end else if (iclkena && ival) begin
      addr_cnt <= isop ? buf_addr_t'(1) : addr_cnt + 1'b1;  // One past this pair.
      in_frame <= !ieop;
    end
  end

  // Flags.
  assign ordy  = !full_all;   // Room in at least one bank.
  assign obusy = !empty_all;  // Some bank still holds a frame.

  //------------------------------
  // Producer protocol
  //------------------------------

  a_sop_needs_rdy : assert property (@(posedge iclk) disable iff (reset)
    (iclkena && ival && isop) |-> ordy);

  a_no_sop_in_frame : assert property (@(posedge iclk) disable iff (reset)
    (iclkena && ival && isop) |-> !in_frame);

  a_no_pair_outside : assert property (@(posedge iclk) disable iff (reset)
    (iclkena && ival && !isop) |-> in_frame);

endmodule

//--- hw/rsc_frame_buffer.sv
/*
  Two-bank ping-pong frame RAM between the source and the engine.
  The source fills one bank while the engine reads the other. A bank
  turns full on the cycle after its last write and stays full until the
  engine releases it. Read data returns one enabled cycle after read.
*/

`include "rsc_defines.svh"

module rsc_frame_buffer (
  input  logic                   iclk,
  input  logic                   reset,
  input  logic                   iclkena,
  input  logic                   write,
  input  logic                   wfull,
  input  rsc_buf_pkg::buf_addr_t waddr,
  input  rsc_code_pkg::sym_t     wdat,
  input  logic                   read,
  input  rsc_buf_pkg::buf_addr_t raddr,
  input  logic                   release_bank,
  output rsc_code_pkg::sym_t     rdat,
  output rsc_buf_pkg::buf_len_t  rlen,
  output logic                   empty_all,
  output logic                   full_all,
  output logic                   full_any
);

  import rsc_buf_pkg::*;
  import rsc_code_pkg::*;

  localparam int DEPTH = `RSC_NBANK * (2 ** `RSC_ADDR_W);  // Pairs over all banks.

  sym_t                  mem [DEPTH];         // Bank index is the address MSB.
  buf_len_t              len [`RSC_NBANK];    // Length minus one, per bank.
  logic [`RSC_NBANK-1:0] full;                // Bank holds a closed frame.
  bank_t                 wbank;               // Bank being filled.
  bank_t                 rbank;               // Bank being read.

  //------------------------------
  // Storage
  //------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && write) begin
      mem[{wbank, waddr}] <= wdat;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && read) begin
      rdat <= mem[{rbank, raddr}];  // Registered read port.
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && wfull) begin
      len[wbank] <= waddr;  // Address of the last pair.
    end
  end

  assign rlen = len[rbank];

  //------------------------------
  // Bank state
  //------------------------------

  // A bank cannot be written and released in one cycle: the writer
  // needs it empty and the reader needs it full.
  always_ff @(posedge iclk) begin
    if (reset) begin
      full  <= '0;
      wbank <= '0;
      rbank <= '0;
    end else if (iclkena) begin
      if (wfull) begin
        full[wbank] <= 1'b1;     // Close it.
        wbank       <= wbank + 1'b1;
      end
      if (release_bank) begin
        full[rbank] <= 1'b0;     // Free it.
        rbank       <= rbank + 1'b1;
      end
    end
  end

  assign empty_all = ~|full;
  assign full_all  = &full;
  assign full_any  = |full;

  //------------------------------
  // Bank handshake checks
  //------------------------------

  a_write_free_bank : assert property (@(posedge iclk) disable iff (reset)
    (iclkena && write) |-> !full[wbank]);

  a_release_full_bank : assert property (@(posedge iclk) disable iff (reset)
    (iclkena && release_bank) |-> full[rbank]);

endmodule

//--- hw/rsc_enc_engine.sv
/*
  Encoder engine. Waits for a full bank, reads its pairs in order and
  runs the duobinary recursive code from the zero state. Each pair comes
  out with its parity {Y,W} two enabled cycles after its read, framed by
  osop and oeop. The bank is released one cycle after the last read.
*/

module rsc_enc_engine (
  input  logic                   iclk,
  input  logic                   reset,
  input  logic                   iclkena,
  input  logic                   full_any,
  input  rsc_buf_pkg::buf_len_t  rlen,
  input  rsc_code_pkg::sym_t     rdat,
  output logic                   read,
  output rsc_buf_pkg::buf_addr_t raddr,
  output logic                   release_bank,
  output logic                   oval,
  output logic                   osop,
  output logic                   oeop,
  output rsc_code_pkg::sym_t     osym,
  output rsc_code_pkg::par_t     opar
);

  import rsc_code_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,  // Waiting for a closed bank.
    ST_RUN,   // One read per enabled cycle.
    ST_REL    // Hand the bank back.
  } eng_state_t;

  eng_state_t state;
  logic       last_addr;  // Current read is the last pair.
  logic       p1_val;     // Read data arrives this cycle.
  logic       p1_first;
  logic       p1_last;
  enc_state_t code_st;    // State after the previous pair.
  enc_state_t code_cur;   // State applied to the pair in stage 1.

  //------------------------------
  // Read sequencer
  //------------------------------

  assign read         = (state == ST_RUN);
  assign release_bank = (state == ST_REL);
  assign last_addr    = (raddr == rlen);

  // Idle is entered after the release, so full_any is already updated.
  always_ff @(posedge iclk) begin
    if (reset) begin
      state <= ST_IDLE;
      raddr <= '0;
    end else if (iclkena) begin
      case (state)
        ST_IDLE : begin
          raddr <= '0;
          if (full_any) begin
            state <= ST_RUN;
          end
        end
        ST_RUN : begin
          raddr <= raddr + 1'b1;
          if (last_addr) begin
            state <= ST_REL;
          end
        end
        default : begin
          state <= ST_IDLE;  // Release lasts one cycle.
        end
      endcase
    end
  end

  //------------------------------
  // Stage 1, RAM latency
  //------------------------------

  always_ff @(posedge iclk) begin
    if (reset) begin
      p1_val   <= 1'b0;
      p1_first <= 1'b0;
      p1_last  <= 1'b0;
    end else if (iclkena) begin
      p1_val   <= read;
      p1_first <= read & (raddr == '0);  // Markers ride with the data.
      p1_last  <= read & last_addr;
    end
  end

  //------------------------------
  // Stage 2, code and output
  //------------------------------

  assign code_cur = p1_first ? '0 : code_st;  // Each frame starts from zero.

  always_ff @(posedge iclk) begin
    if (reset) begin
      oval    <= 1'b0;
      osop    <= 1'b0;
      oeop    <= 1'b0;
      code_st <= '0;
    end else if (iclkena) begin
      oval <= p1_val;
      osop <= p1_first;
      oeop <= p1_last;
      if (p1_val) begin
        code_st <= code_next(rdat, code_cur);
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && p1_val) begin
      osym <= rdat;                      // Systematic pair.
      opar <= code_par(rdat, code_cur);  // {Y,W}.
    end
  end

endmodule

//--- hw/rsc_enc_top.sv
/*
  Top level of the duobinary RSC encoder core. Framed input pairs pass
  through the ping-pong buffer to the engine, which emits each pair with
  its parity. ordy throttles the producer; the output has no back-pressure.
*/

module rsc_enc_top (
  input  logic               iclk,
  input  logic               reset,
  input  logic               iclkena,
  input  logic               ival,
  input  logic               isop,
  input  logic               ieop,
  input  rsc_code_pkg::sym_t idat,
  output logic               obusy,
  output logic               ordy,
  output logic               oval,
  output logic               osop,
  output logic               oeop,
  output rsc_code_pkg::sym_t osym,
  output rsc_code_pkg::par_t opar
);

  import rsc_buf_pkg::*;
  import rsc_code_pkg::*;

  //------------------------------
  // Interconnect
  //------------------------------

  logic      write;         // Source to buffer.
  logic      wfull;
  buf_addr_t waddr;
  sym_t      wdat;
  logic      empty_all;     // Buffer flags.
  logic      full_all;
  logic      full_any;
  logic      read;          // Engine to buffer.
  buf_addr_t raddr;
  logic      release_bank;
  sym_t      rdat;          // Buffer to engine.
  buf_len_t  rlen;

  rsc_enc_source source_inst (
    .iclk      (iclk),
    .reset     (reset),
    .iclkena   (iclkena),
    .ival      (ival),
    .isop      (isop),
    .ieop      (ieop),
    .idat      (idat),
    .empty_all (empty_all),
    .full_all  (full_all),
    .obusy     (obusy),
    .ordy      (ordy),
    .write     (write),
    .wfull     (wfull),
    .waddr     (waddr),
    .wdat      (wdat)
  );

  rsc_frame_buffer buffer_inst (
    .iclk         (iclk),
    .reset        (reset),
    .iclkena      (iclkena),
    .write        (write),
    .wfull        (wfull),
    .waddr        (waddr),
    .wdat         (wdat),
    .read         (read),
    .raddr        (raddr),
    .release_bank (release_bank),
    .rdat         (rdat),
    .rlen         (rlen),
    .empty_all    (empty_all),
    .full_all     (full_all),
    .full_any     (full_any)
  );

  rsc_enc_engine engine_inst (
    .iclk         (iclk),
    .reset        (reset),
    .iclkena      (iclkena),
    .full_any     (full_any),
    .rlen         (rlen),
    .rdat         (rdat),
    .read         (read),
    .raddr        (raddr),
    .release_bank (release_bank),
    .oval         (oval),
    .osop         (osop),
    .oeop         (oeop),
    .osym         (osym),
    .opar         (opar)
  );

endmodule

//--- testbench/rsc_enc_tb.sv
/*
  Testbench for the duobinary RSC encoder core. Sends random frames with
  random ival gaps and random iclkena low cycles, predicts every output
  pair and its parity {Y,W} with a behavioural code model, and compares
  the output stream pair by pair. Stops at the first mismatch.
*/

`include "rsc_defines.svh"

module rsc_enc_tb;

  import rsc_code_pkg::*;

  localparam int MAX_LEN    = 2 ** `RSC_ADDR_W;  // Longest frame.
  localparam int NUM_FRAMES = 40;
  localparam int WAIT_LIMIT = 4000;              // Cycles per bounded wait.

  logic        iclk;
  logic        reset;
  logic        iclkena;
  logic        ival;
  logic        isop;
  logic        ieop;
  sym_t        idat;
  logic        obusy;
  logic        ordy;
  logic        oval;
  logic        osop;
  logic        oeop;
  sym_t        osym;
  par_t        opar;

  logic [31:0] seed = 32'hedc8_f389;  // LCG state.
  logic        edge_en;               // Enable seen at the last edge.
  logic        saw_full = 1'b0;       // ordy went low at least once.
  sym_t        exp_sym [$];           // Expected output stream.
  par_t        exp_par [$];
  logic        exp_sop [$];
  logic        exp_eop [$];

  rsc_enc_top rsc_enc_top_inst (
    .iclk    (iclk),
    .reset   (reset),
    .iclkena (iclkena),
    .ival    (ival),
    .isop    (isop),
    .ieop    (ieop),
    .idat    (idat),
    .obusy   (obusy),
    .ordy    (ordy),
    .oval    (oval),
    .osop    (osop),
    .oeop    (oeop),
    .osym    (osym),
    .opar    (opar)
  );

  always #10 iclk = ~iclk;  // Period 20.

  //------------------------------
  // Helpers
  //------------------------------

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped.");
  endtask

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      stop_with_failure("Value mismatch.");
    end
  endtask

  // One clock edge, then a new random enable 1 unit later.
  task automatic tick();
    logic [31:0] r;
    @(posedge iclk);
    edge_en = iclkena;
    #1;
    r = next_rand();
    iclkena = (r[31:29] != 3'd0);  // Low about one cycle in eight.
  endtask

  task automatic hold_until_accepted();
    int n;
    n = 0;
    edge_en = 1'b0;
    while (!edge_en) begin
      if (n >= WAIT_LIMIT) begin
        stop_with_failure("Timeout waiting for an enabled clock edge.");
      end else begin
        tick();
        n++;
      end
    end
  endtask

  task automatic wait_for_ready();
    int n;
    n = 0;
    while (!ordy) begin
      if (n >= WAIT_LIMIT) begin
        stop_with_failure("Timeout waiting for ordy before a new frame.");
      end else begin
        tick();
        n++;
      end
    end
  endtask

  //------------------------------
  // Stimulus and code model
  //------------------------------

  task automatic send_frame(int len, logic dense);
    enc_state_t  st;   // {s1,s2,s3}.
    sym_t        d;
    logic        f;
    logic [31:0] r;
    int          gap;
    int          i;
    st = '0;           // Every frame starts from zero.
    wait_for_ready();
    for (i = 0; i < len; i++) begin
      r = next_rand();
      if (!dense && i > 0 && r[31:29] == 3'd0) begin
        gap = int'(r[27:26]) + 1;
        repeat (gap) tick();                  // ival gap inside the frame.
      end
      d = r[21:20];
      f = d[1] ^ d[0] ^ st[2] ^ st[0];        // A^B^s1^s3.
      exp_sym.push_back(d);
      exp_par.push_back({f ^ st[1] ^ st[0], f ^ st[0]});
      exp_sop.push_back(i == 0);
      exp_eop.push_back(i == len - 1);
      st = {f, st[2] ^ d[0], st[1] ^ d[0]};
      ival = 1'b1;
      isop = (i == 0);
      ieop = (i == len - 1);
      idat = d;
      hold_until_accepted();
      ival = 1'b0;
      isop = 1'b0;
      ieop = 1'b0;
    end
    check("obusy", 32'(obusy), 32'd1);         // Closed bank is stored.
  endtask

  //------------------------------
  // Output monitor
  //------------------------------

  // At the falling edge iclkena already holds the value for the next edge.
  always @(negedge iclk) begin
    if (!reset) begin
      if (!ordy) begin
        saw_full = 1'b1;
      end
      if (iclkena && oval) begin
        if (exp_sym.size() == 0) begin
          stop_with_failure("Output pair seen with no input pair pending.");
        end else begin
          check("osym", 32'(osym), 32'(exp_sym.pop_front()));
          check("opar", 32'(opar), 32'(exp_par.pop_front()));
          check("osop", 32'(osop), 32'(exp_sop.pop_front()));
          check("oeop", 32'(oeop), 32'(exp_eop.pop_front()));
        end
      end
    end
  end

  //------------------------------
  // Main sequence
  //------------------------------

  initial begin
    int          frame;
    int          len;
    int          n;
    logic [31:0] r;
    iclk    = 1'b0;
    reset   = 1'b1;
    iclkena = 1'b1;
    ival    = 1'b0;
    isop    = 1'b0;
    ieop    = 1'b0;
    idat    = '0;
    edge_en = 1'b0;
    repeat (3) @(posedge iclk);  // Reset for 3 cycles.
    #1;
    reset = 1'b0;
    check("ordy", 32'(ordy), 32'd1);
    check("obusy", 32'(obusy), 32'd0);
    check("oval", 32'(oval), 32'd0);

    // Long frame then a single pair fills both banks.
    for (frame = 0; frame < NUM_FRAMES; frame++) begin
      if (frame == 0) begin
        len = MAX_LEN;
      end else if (frame == 1) begin
        len = 1;
      end else begin
        r   = next_rand();
        len = int'((r >> 16) % 32'(MAX_LEN)) + 1;
      end
      send_frame(len, frame < 4);  // First frames back to back.
    end

    n = 0;
    while (exp_sym.size() != 0) begin
      if (n >= WAIT_LIMIT) begin
        stop_with_failure("Timeout waiting for the encoder to drain.");
      end else begin
        tick();
        n++;
      end
    end
    check("ordy_low_seen", 32'(saw_full), 32'd1);
    check("obusy", 32'(obusy), 32'd0);  // Last bank freed before its last pair.

    $display("** PASS **");
    $finish;
  end

endmodule

//--- sim.f
+incdir+hw
hw/rsc_buf_pkg.sv
hw/rsc_code_pkg.sv
hw/rsc_enc_source.sv
hw/rsc_frame_buffer.sv
hw/rsc_enc_engine.sv
hw/rsc_enc_top.sv
testbench/rsc_enc_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the duobinary RSC encoder core.

VERILATOR ?= verilator
TOP       ?= rsc_enc_tb
LINT_TOP  ?= rsc_enc_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
